/* design/udp_echo_pkg.sv */
// ==================================================
// Widths and field types shared by the echo core
// Payload is fixed at 64 bits with one keep bit per byte
// ==================================================
package udp_echo_pkg;

    // Payload stream
    parameter int DATA_W = 64;
    parameter int KEEP_W = DATA_W / 8;

    // Status display
    parameter int LED_W = 8;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [KEEP_W-1:0] keep_t;

    // Header fields as delivered by the UDP stack
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    typedef logic [LED_W-1:0] led_t;

    // Port that gets echoed
    parameter udp_port_t DEFAULT_LISTEN_PORT = 16'd1234;

    // Payload buffer size in beats, power of two
    parameter int DEFAULT_FIFO_DEPTH = 64;

endpackage

/* design/udp_rx_filter.sv */
// ==================================================
// Steers frames for LISTEN_PORT into the payload FIFO
// Other frames are consumed up to tlast and dropped
// Assumes every header is followed by a payload with tlast
// ==================================================
module udp_rx_filter #(
    parameter udp_echo_pkg::udp_port_t LISTEN_PORT = udp_echo_pkg::DEFAULT_LISTEN_PORT
) (
    input  logic                     clk,
    input  logic                     rst,

    // Parsed UDP header from the stack
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t   rx_ip_source_ip,
    input  udp_echo_pkg::udp_port_t  rx_source_port,
    input  udp_echo_pkg::udp_port_t  rx_dest_port,
    input  udp_echo_pkg::udp_len_t   rx_length,

    // Received payload
    input  udp_echo_pkg::data_t      rx_payload_tdata,
    input  udp_echo_pkg::keep_t      rx_payload_tkeep,
    input  logic                     rx_payload_tvalid,
    output logic                     rx_payload_tready,
    input  logic                     rx_payload_tlast,
    input  logic                     rx_payload_tuser,

    // Swapped reply header
    output logic                     hdr_valid,
    input  logic                     hdr_ready,
    output udp_echo_pkg::ip_addr_t   reply_dest_ip,
    output udp_echo_pkg::udp_port_t  reply_source_port,
    output udp_echo_pkg::udp_port_t  reply_dest_port,
    output udp_echo_pkg::udp_len_t   reply_length,

    // FIFO write side
    output logic                     wr_valid,
    input  logic                     wr_ready,
    output udp_echo_pkg::data_t      wr_data,
    output udp_echo_pkg::keep_t      wr_keep,
    output logic                     wr_last,
    output logic                     wr_user
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_FWD  = 2'd1;
    localparam logic [1:0] ST_DROP = 2'd2;

    logic [1:0] state;
    logic       port_match;
    logic       in_idle;
    logic       in_fwd;
    logic       in_drop;
    logic       hdr_xfer;
    logic       last_xfer;

    assign port_match = rx_dest_port == LISTEN_PORT;
    assign in_idle    = state == ST_IDLE;
    assign in_fwd     = state == ST_FWD;
    assign in_drop    = state == ST_DROP;

    // A dropped header never waits on the reply register
    assign rx_hdr_ready = in_idle && (hdr_ready || !port_match);
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;

    // Reply header leaves in the same cycle, fields swapped
    assign hdr_valid         = in_idle && rx_hdr_valid && port_match;
    assign reply_dest_ip     = rx_ip_source_ip;
    assign reply_source_port = rx_dest_port;
    assign reply_dest_port   = rx_source_port;
    assign reply_length      = rx_length;

    // Payload steering
    assign wr_valid          = in_fwd && rx_payload_tvalid;
    assign rx_payload_tready = in_drop || (in_fwd && wr_ready);
    assign wr_data           = rx_payload_tdata;
    assign wr_keep           = rx_payload_tkeep;
    assign wr_last           = rx_payload_tlast;
    assign wr_user           = rx_payload_tuser;

    assign last_xfer = rx_payload_tvalid && rx_payload_tready && rx_payload_tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? ST_FWD : ST_DROP;
                    end
                end
                ST_FWD, ST_DROP: begin
                    // Frame ends on the tlast beat
                    if (last_xfer) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/udp_payload_fifo.sv */
// ==================================================
// Payload buffer with a registered read port
// FIFO_DEPTH must be a power of two, at least 4
// ==================================================
module udp_payload_fifo #(
    parameter int FIFO_DEPTH = udp_echo_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,

    // Write side, from the filter
    input  logic                 wr_valid,
    output logic                 wr_ready,
    input  udp_echo_pkg::data_t  wr_data,
    input  udp_echo_pkg::keep_t  wr_keep,
    input  logic                 wr_last,
    input  logic                 wr_user,

    // Read side, to the reply path
    output logic                 rd_valid,
    input  logic                 rd_ready,
    output udp_echo_pkg::data_t  rd_data,
    output udp_echo_pkg::keep_t  rd_keep,
    output logic                 rd_last,
    output logic                 rd_user
);

    import udp_echo_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

    data_t mem_data [FIFO_DEPTH];
    keep_t mem_keep [FIFO_DEPTH];
    logic  mem_last [FIFO_DEPTH];
    logic  mem_user [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // Beats held in memory, not counting the output register
    logic [PTR_W:0]   count;
    logic             wr_xfer;
    logic             load;

    assign wr_ready = count != FULL_COUNT;
    assign wr_xfer  = wr_valid && wr_ready;

    // Refill the output register when it is empty or being taken
    assign load = (count != '0) && (!rd_valid || rd_ready);

    always_ff @(posedge clk) begin
        if (wr_xfer) begin
            mem_data[wr_ptr] <= wr_data;
            mem_keep[wr_ptr] <= wr_keep;
            mem_last[wr_ptr] <= wr_last;
            mem_user[wr_ptr] <= wr_user;
        end
        if (load) begin
            rd_data <= mem_data[rd_ptr];
            rd_keep <= mem_keep[rd_ptr];
            rd_last <= mem_last[rd_ptr];
            rd_user <= mem_user[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_xfer) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_xfer && !load) begin
                count <= count + 1'b1;
            end else if (!wr_xfer && load) begin
                count <= count - 1'b1;
            end
            if (load) begin
                rd_valid <= 1'b1;
            end else if (rd_ready) begin
                rd_valid <= 1'b0;
            end
        end
    end

endmodule

/* design/udp_reply_tx.sv */
// ==================================================
// One-entry reply header register and payload output
// led shows the low byte of each frame's first beat
// ==================================================
module udp_reply_tx (
    input  logic                     clk,
    input  logic                     rst,

    // Reply header from the filter
    input  logic                     hdr_valid,
    output logic                     hdr_ready,
    input  udp_echo_pkg::ip_addr_t   reply_dest_ip,
    input  udp_echo_pkg::udp_port_t  reply_source_port,
    input  udp_echo_pkg::udp_port_t  reply_dest_port,
    input  udp_echo_pkg::udp_len_t   reply_length,

    // FIFO read side
    input  logic                     rd_valid,
    output logic                     rd_ready,
    input  udp_echo_pkg::data_t      rd_data,
    input  udp_echo_pkg::keep_t      rd_keep,
    input  logic                     rd_last,
    input  logic                     rd_user,

    // Transmit header to the stack
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t   tx_ip_dest_ip,
    output udp_echo_pkg::udp_port_t  tx_source_port,
    output udp_echo_pkg::udp_port_t  tx_dest_port,
    output udp_echo_pkg::udp_len_t   tx_length,

    // Transmit payload to the stack
    output udp_echo_pkg::data_t      tx_payload_tdata,
    output udp_echo_pkg::keep_t      tx_payload_tkeep,
    output logic                     tx_payload_tvalid,
    input  logic                     tx_payload_tready,
    output logic                     tx_payload_tlast,
    output logic                     tx_payload_tuser,

    output udp_echo_pkg::led_t       led
);

    import udp_echo_pkg::*;

    logic hdr_load;
    logic beat_xfer;
    // Next transferred beat opens a frame
    logic first_beat;

    // Register can take a new header while the old one leaves
    assign hdr_ready = !tx_hdr_valid || tx_hdr_ready;
    assign hdr_load  = hdr_valid && hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
        end else if (hdr_load) begin
            tx_hdr_valid <= 1'b1;
        end else if (tx_hdr_ready) begin
            tx_hdr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_load) begin
            tx_ip_dest_ip  <= reply_dest_ip;
            tx_source_port <= reply_source_port;
            tx_dest_port   <= reply_dest_port;
            tx_length      <= reply_length;
        end
    end

    // Payload goes straight out of the FIFO output register
    assign tx_payload_tdata  = rd_data;
    assign tx_payload_tkeep  = rd_keep;
    assign tx_payload_tvalid = rd_valid;
    assign tx_payload_tlast  = rd_last;
    assign tx_payload_tuser  = rd_user;
    assign rd_ready          = tx_payload_tready;

    assign beat_xfer = rd_valid && tx_payload_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= '0;
        end else if (beat_xfer) begin
            if (first_beat) begin
                led <= rd_data[LED_W-1:0];
            end
            first_beat <= rd_last;
        end
    end

endmodule

/* design/udp_echo_core.sv */
// ==================================================
// UDP echo core behind an external UDP stack
// Constant reply fields are left to the stack
// ==================================================
module udp_echo_core #(
    parameter udp_echo_pkg::udp_port_t LISTEN_PORT = udp_echo_pkg::DEFAULT_LISTEN_PORT,
    parameter int FIFO_DEPTH = udp_echo_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                     clk,
    input  logic                     rst,

    // Receive header
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t   rx_ip_source_ip,
    input  udp_echo_pkg::udp_port_t  rx_source_port,
    input  udp_echo_pkg::udp_port_t  rx_dest_port,
    input  udp_echo_pkg::udp_len_t   rx_length,

    // Receive payload
    input  udp_echo_pkg::data_t      rx_payload_tdata,
    input  udp_echo_pkg::keep_t      rx_payload_tkeep,
    input  logic                     rx_payload_tvalid,
    output logic                     rx_payload_tready,
    input  logic                     rx_payload_tlast,
    input  logic                     rx_payload_tuser,

    // Transmit header
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t   tx_ip_dest_ip,
    output udp_echo_pkg::udp_port_t  tx_source_port,
    output udp_echo_pkg::udp_port_t  tx_dest_port,
    output udp_echo_pkg::udp_len_t   tx_length,

    // Transmit payload
    output udp_echo_pkg::data_t      tx_payload_tdata,
    output udp_echo_pkg::keep_t      tx_payload_tkeep,
    output logic                     tx_payload_tvalid,
    input  logic                     tx_payload_tready,
    output logic                     tx_payload_tlast,
    output logic                     tx_payload_tuser,

    output udp_echo_pkg::led_t       led
);

    import udp_echo_pkg::*;

    // Filter to reply register
    logic      hdr_valid;
    logic      hdr_ready;
    ip_addr_t  reply_dest_ip;
    udp_port_t reply_source_port;
    udp_port_t reply_dest_port;
    udp_len_t  reply_length;

    // Filter to FIFO
    logic      wr_valid;
    logic      wr_ready;
    data_t     wr_data;
    keep_t     wr_keep;
    logic      wr_last;
    logic      wr_user;

    // FIFO to transmit side
    logic      rd_valid;
    logic      rd_ready;
    data_t     rd_data;
    keep_t     rd_keep;
    logic      rd_last;
    logic      rd_user;

    udp_rx_filter #(
        .LISTEN_PORT(LISTEN_PORT)
    ) u_rx_filter (
        .clk               (clk),
        .rst               (rst),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_ip_source_ip   (rx_ip_source_ip),
        .rx_source_port    (rx_source_port),
        .rx_dest_port      (rx_dest_port),
        .rx_length         (rx_length),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tkeep  (rx_payload_tkeep),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tready (rx_payload_tready),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tuser  (rx_payload_tuser),
        .hdr_valid         (hdr_valid),
        .hdr_ready         (hdr_ready),
        .reply_dest_ip     (reply_dest_ip),
        .reply_source_port (reply_source_port),
        .reply_dest_port   (reply_dest_port),
        .reply_length      (reply_length),
        .wr_valid          (wr_valid),
        .wr_ready          (wr_ready),
        .wr_data           (wr_data),
        .wr_keep           (wr_keep),
        .wr_last           (wr_last),
        .wr_user           (wr_user)
    );

    udp_payload_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_payload_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_data  (wr_data),
        .wr_keep  (wr_keep),
        .wr_last  (wr_last),
        .wr_user  (wr_user),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready),
        .rd_data  (rd_data),
        .rd_keep  (rd_keep),
        .rd_last  (rd_last),
        .rd_user  (rd_user)
    );

    udp_reply_tx u_reply_tx (
        .clk               (clk),
        .rst               (rst),
        .hdr_valid         (hdr_valid),
        .hdr_ready         (hdr_ready),
        .reply_dest_ip     (reply_dest_ip),
        .reply_source_port (reply_source_port),
        .reply_dest_port   (reply_dest_port),
        .reply_length      (reply_length),
        .rd_valid          (rd_valid),
        .rd_ready          (rd_ready),
        .rd_data           (rd_data),
        .rd_keep           (rd_keep),
        .rd_last           (rd_last),
        .rd_user           (rd_user),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_ip_dest_ip     (tx_ip_dest_ip),
        .tx_source_port    (tx_source_port),
        .tx_dest_port      (tx_dest_port),
        .tx_length         (tx_length),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tkeep  (tx_payload_tkeep),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast),
        .tx_payload_tuser  (tx_payload_tuser),
        .led               (led)
    );

endmodule

/* sim/udp_echo_tests.svh */
// ==================================================
// Directed tests, included inside tb_udp_echo
// Only frames to DEFAULT_LISTEN_PORT are echoed
// ==================================================

task automatic test_reset_state();
    @(posedge clk);
    check_value("reset tx_hdr_valid", 80'(1'b0), 80'(tx_hdr_valid));
    check_value("reset tx_payload_tvalid", 80'(1'b0), 80'(tx_payload_tvalid));
    check_value("reset led", 80'(8'd0), 80'(led));
    check_value("reset rx_hdr_ready", 80'(1'b1), 80'(rx_hdr_ready));
endtask

task automatic test_single_echo();
    send_frame(32'h0A00_0105, 16'd40000, DEFAULT_LISTEN_PORT, 4, 1'b1);
    check_outputs("single echo");
endtask

task automatic test_drop_port();
    int stalls_before;
    stalls_before = rx_stall_cycles;
    send_frame(32'h0A00_0107, 16'd5000, 16'd1235, 5, 1'b0);
    // Dropped beats are taken on every cycle
    check_value("drop input stalls", 80'(0), 80'(rx_stall_cycles - stalls_before));
    // Any output would show within the 1 cycle header latency plus FIFO latency
    repeat (4) @(negedge clk);
    check_outputs("drop");
    check_value("drop led", 80'(exp_led), 80'(led));
    send_frame(32'h0A00_0108, 16'd5001, DEFAULT_LISTEN_PORT, 3, 1'b1);
    check_outputs("echo after drop");
endtask

// Frames go in back to back while both tx channels stall at random
task automatic test_back_pressure();
    int lengths[6] = '{1, 3, 7, 2, 12, 5};
    random_ready = 1'b1;
    for (int f = 0; f < 6; f++) begin
        send_frame(32'hC0A8_0010 + ip_addr_t'(f), udp_port_t'(2000 + f),
                   DEFAULT_LISTEN_PORT, lengths[f], 1'b1);
    end
    check_outputs("back-pressure");
    random_ready = 1'b0;
endtask

task automatic test_led_capture();
    for (int f = 0; f < 3; f++) begin
        send_frame(32'h0A00_0200 + ip_addr_t'(f), 16'd6000, DEFAULT_LISTEN_PORT, f + 1, 1'b1);
        check_outputs("led frame");
        check_value("led after echo", 80'(exp_led), 80'(led));
    end
    // Dropped frame must leave the display alone
    send_frame(32'h0A00_0210, 16'd6001, 16'd80, 2, 1'b0);
    repeat (4) @(negedge clk);
    check_outputs("led drop");
    check_value("led after drop", 80'(exp_led), 80'(led));
endtask

/* sim/tb_udp_echo.sv */
// ==================================================
// Testbench for udp_echo_core with default parameters
// Inputs change on the falling edge, outputs sampled on the rising edge
// ==================================================
module tb_udp_echo;

    import udp_echo_pkg::*;

    localparam int MAX_CYCLES = 4000;

    logic      clk, rst;
    logic      rx_hdr_valid, rx_hdr_ready, rx_payload_tvalid, rx_payload_tready;
    logic      rx_payload_tlast, rx_payload_tuser;
    ip_addr_t  rx_ip_source_ip, tx_ip_dest_ip;
    udp_port_t rx_source_port, rx_dest_port, tx_source_port, tx_dest_port;
    udp_len_t  rx_length, tx_length;
    data_t     rx_payload_tdata, tx_payload_tdata;
    keep_t     rx_payload_tkeep, tx_payload_tkeep;
    logic      tx_hdr_valid, tx_hdr_ready, tx_payload_tvalid, tx_payload_tready;
    logic      tx_payload_tlast, tx_payload_tuser;
    led_t      led;

    // Header as {ip, source port, dest port, length}
    logic [79:0] exp_hdr[$], got_hdr[$];
    // Beat as {user, last, keep, data}
    logic [73:0] exp_beat[$], got_beat[$];
    logic [31:0] data_state = 32'd69;
    logic        random_ready = 1'b0;
    logic        timed_out = 1'b0;
    led_t        exp_led = '0;
    int          value_errors = 0, other_errors = 0, cycle_count = 0;
    // Cycles a payload beat waited for rx_payload_tready
    int          rx_stall_cycles = 0;

    udp_echo_core uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Sink stays ready unless a test asks for stalls
    initial begin
        logic [31:0] ready_state;
        ready_state = 32'd69;
        tx_hdr_ready = 1'b1;
        tx_payload_tready = 1'b1;
        forever begin
            @(negedge clk);
            ready_state = xorshift32(ready_state);
            tx_hdr_ready = !random_ready || ready_state[3];
            tx_payload_tready = !random_ready || ready_state[11];
        end
    end

    // Collect every transfer on the tx side
    always @(posedge clk) begin
        if (!rst) begin
            if (tx_hdr_valid && tx_hdr_ready) begin
                got_hdr.push_back({tx_ip_dest_ip, tx_source_port, tx_dest_port, tx_length});
            end
            if (tx_payload_tvalid && tx_payload_tready) begin
                got_beat.push_back({tx_payload_tuser, tx_payload_tlast, tx_payload_tkeep,
                                    tx_payload_tdata});
            end
        end
    end

    task automatic check_value(input string test, input logic [79:0] expected,
                               input logic [79:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("FAILED %s: expected %h, actual %h", test, expected, actual);
        end
    endtask

    // Sends a header then nbeats random beats and queues the expected echo
    task automatic send_frame(input ip_addr_t ip, input udp_port_t sport,
                              input udp_port_t dport, input int nbeats, input logic echo);
        keep_t last_keep;
        data_state = xorshift32(data_state);
        last_keep = keep_t'(8'hFF >> data_state[2:0]);
        @(negedge clk);
        rx_hdr_valid = 1'b1;
        rx_ip_source_ip = ip;
        rx_source_port = sport;
        rx_dest_port = dport;
        rx_length = udp_len_t'(8 * nbeats + $countones(last_keep));
        @(posedge clk);
        while (!rx_hdr_ready) begin
            @(posedge clk);
        end
        // Reply goes back to the sender with ports swapped and length kept
        if (echo) begin
            exp_hdr.push_back({ip, dport, sport, rx_length});
        end
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < nbeats; i++) begin
            data_state = xorshift32(data_state);
            rx_payload_tdata[63:32] = data_state;
            data_state = xorshift32(data_state);
            rx_payload_tdata[31:0] = data_state;
            rx_payload_tlast = i == nbeats - 1;
            rx_payload_tkeep = rx_payload_tlast ? last_keep : '1;
            rx_payload_tuser = data_state[7];
            rx_payload_tvalid = 1'b1;
            if (echo) begin
                exp_beat.push_back({rx_payload_tuser, rx_payload_tlast, rx_payload_tkeep,
                                    rx_payload_tdata});
                if (i == 0) begin
                    exp_led = rx_payload_tdata[LED_W-1:0];
                end
            end
            @(posedge clk);
            while (!rx_payload_tready) begin
                rx_stall_cycles++;
                @(posedge clk);
            end
            @(negedge clk);
        end
        rx_payload_tvalid = 1'b0;
    endtask

    // Waits for all expected output, then compares headers and beats in order
    task automatic check_outputs(input string test);
        while (got_hdr.size() < exp_hdr.size() || got_beat.size() < exp_beat.size()) begin
            @(negedge clk);
        end
        assert (got_hdr.size() == exp_hdr.size() && got_beat.size() == exp_beat.size())
        else begin
            other_errors++;
            $display("%s: got %0d headers and %0d beats, but %0d and %0d were due", test,
                     got_hdr.size(), got_beat.size(), exp_hdr.size(), exp_beat.size());
        end
        while (exp_hdr.size() > 0 && got_hdr.size() > 0) begin
            check_value(test, exp_hdr.pop_front(), got_hdr.pop_front());
        end
        while (exp_beat.size() > 0 && got_beat.size() > 0) begin
            check_value(test, 80'(exp_beat.pop_front()), 80'(got_beat.pop_front()));
        end
        exp_hdr.delete();
        got_hdr.delete();
        exp_beat.delete();
        got_beat.delete();
    endtask

    task automatic finish_run();
        $display("Value errors: %0d, other errors: %0d", value_errors,
                 other_errors + int'(timed_out));
        if (value_errors == 0 && other_errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    `include "udp_echo_tests.svh"

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        timed_out = 1'b1;
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        finish_run();
    end

    initial begin
        rst = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_ip_source_ip = '0;
        rx_source_port = '0;
        rx_dest_port = '0;
        rx_length = '0;
        rx_payload_tdata = '0;
        rx_payload_tkeep = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast = 1'b0;
        rx_payload_tuser = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_single_echo();
        test_drop_port();
        test_back_pressure();
        test_led_capture();
        finish_run();
    end

endmodule

/* compile.f */
+incdir+sim
design/udp_echo_pkg.sv
design/udp_rx_filter.sv
design/udp_payload_fifo.sv
design/udp_reply_tx.sv
design/udp_echo_core.sv
sim/tb_udp_echo.sv

/* run_sim.sh */
#!/bin/sh
# Build the echo core testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_udp_echo \
    -Mdir obj_dir -o tb_udp_echo

./obj_dir/tb_udp_echo > sim.log
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
